// ==== cache_settings.svh ====
/* data cache geometry and main memory model constants
   shared by the cache RTL, the memory model and the testbench */
`ifndef CACHE_SETTINGS_SVH
`define CACHE_SETTINGS_SVH

`define ADDR_W        16                    // byte address and data word width
`define TAG_W         5                     // addr[15:11]
`define INDEX_W       7                     // addr[10:4], one block per index
`define OFFSET_W      3                     // addr[3:1], word within the block

// derived geometry
`define NUM_BLOCKS    (1 << `INDEX_W)       // 128 blocks
`define BLOCK_WORDS   (1 << `OFFSET_W)      // 8 words per block
`define MEM_WORDS     (1 << (`ADDR_W - 1))  // addr[0] is always zero

// main memory model
`define MEM_LATENCY   4                     // read command to mem_data_vld, in cycles
`define MEM_INIT_XOR  16'hA5C3              // word w starts as w ^ MEM_INIT_XOR

`endif

// ==== cache_types_pkg.sv ====
/* data cache types
   fill machine state encoding */
`default_nettype none

package cache_types_pkg;

	// block fill sequence, one pass per miss
	typedef enum logic [1:0] {
		ST_IDLE  = 2'd0, // serving hits, waiting for a miss
		ST_FETCH = 2'd1, // issuing the eight block reads
		ST_DRAIN = 2'd2, // all reads issued, last returns still in flight
		ST_TAG   = 2'd3  // block complete, write tag and valid
	} fill_state_e;

	// ST_IDLE -> ST_FETCH on a miss with the icache fill idle
	// ST_FETCH -> ST_DRAIN after offset 7 is requested
	// ST_DRAIN -> ST_TAG on the eighth return
	// ST_TAG -> ST_IDLE unconditionally

endpackage

`default_nettype wire

// ==== dcache.sv ====
/* direct mapped write-through write-allocate data cache
   address split, write data select, arrays and fill machine */
`timescale 1ns/1ps
`default_nettype none

`include "cache_settings.svh"

module dcache (
	input  logic                    clk,
	input  logic                    reset,
	input  logic                    mem_en,       // request live
	input  logic                    wrt_en,       // store
	input  logic [`ADDR_W-1:0]      addr_in,
	input  logic [`ADDR_W-1:0]      reg_in,       // store data from the register file
	input  logic                    pause,        // icache fill busy
	input  logic [`ADDR_W-1:0]      mem_data,
	input  logic                    mem_data_vld,
	output logic [`ADDR_W-1:0]      data_out,
	output logic                    fsm_busy,     // stall to the pipeline
	output mem_types_pkg::mem_cmd_e mem_cmd,
	output logic [`ADDR_W-1:0]      mem_addr,
	output logic [`ADDR_W-1:0]      mem_wdata
);

	logic [`ADDR_W-1:0]   cache_addr;  // addr_in, or the fill word address
	logic [`TAG_W-1:0]    tag;
	logic [`INDEX_W-1:0]  index;
	logic [`OFFSET_W-1:0] offset;
	logic [`ADDR_W-1:0]   data_in;
	logic                 array_hit;   // valid and tag match
	logic                 hit;
	logic                 fill_write;
	logic                 write_tag;

	// tag 15:11, index 10:4, word offset 3:1, bit 0 always zero
	assign tag    = cache_addr[`ADDR_W-1 -: `TAG_W];
	assign index  = cache_addr[`OFFSET_W+1 +: `INDEX_W];
	assign offset = cache_addr[1 +: `OFFSET_W];

	assign hit = ~mem_en | array_hit; // no access counts as a hit, nothing to fetch

	// during a fill the tag never matches, so mem_data is selected
	assign data_in   = hit ? reg_in : mem_data;
	assign mem_wdata = reg_in;        // only write hits go to memory

	dcache_tag_array u_tag (
		.clk       (clk),
		.reset     (reset),
		.index     (index),
		.tag       (tag),
		.write_tag (write_tag),
		.hit       (array_hit)
	);

	dcache_data_array u_data (
		.clk      (clk),
		.index    (index),
		.offset   (offset),
		.write    (fill_write),
		.data_in  (data_in),
		.data_out (data_out)
	);

	dcache_fill_fsm u_fsm (
		.clk          (clk),
		.reset        (reset),
		.req          (mem_en),
		.wrt_en       (wrt_en),
		.hit          (hit),
		.addr_in      (addr_in),
		.pause        (pause),
		.mem_data_vld (mem_data_vld),
		.fsm_busy     (fsm_busy),
		.fill_write   (fill_write),
		.write_tag    (write_tag),
		.cache_addr   (cache_addr),
		.mem_cmd      (mem_cmd),
		.mem_addr     (mem_addr)
	);

endmodule

`default_nettype wire

// ==== dcache_data_array.sv ====
/* dcache data array, 128 blocks of eight 16-bit words
   combinational read, single word write at the clock edge */
`timescale 1ns/1ps
`default_nettype none

`include "cache_settings.svh"

module dcache_data_array (
	input  logic                 clk,
	input  logic [`INDEX_W-1:0]  index,    // block
	input  logic [`OFFSET_W-1:0] offset,   // word within block
	input  logic                 write,    // write hit or fill return
	input  logic [`ADDR_W-1:0]   data_in,
	output logic [`ADDR_W-1:0]   data_out
);

	// block x word organisation, 1024 words total
	logic [`ADDR_W-1:0] blocks [`NUM_BLOCKS][`BLOCK_WORDS];

	// one word per cycle, either reg_in or mem_data
	always_ff @(posedge clk) begin
		if (write) begin
			blocks[index][offset] <= data_in;
		end
	end

	// read follows index/offset in the same cycle, so a read hit
	// needs no extra pipeline stage in front of the processor
	assign data_out = blocks[index][offset];

endmodule

`default_nettype wire

// ==== dcache_fill_fsm.sv ====
/* dcache fill machine, sequences block fetch on a miss
   and issues the write-through command on a write hit */
`timescale 1ns/1ps
`default_nettype none

`include "cache_settings.svh"

module dcache_fill_fsm (
	input  logic                    clk,
	input  logic                    reset,
	input  logic                    req,          // mem_en from the pipeline
	input  logic                    wrt_en,       // request is a store
	input  logic                    hit,          // from the tag compare
	input  logic [`ADDR_W-1:0]      addr_in,      // held stable while fsm_busy
	input  logic                    pause,        // icache fill in progress
	input  logic                    mem_data_vld, // one fill word returning
	output logic                    fsm_busy,     // pipeline stall
	output logic                    fill_write,   // data array write strobe
	output logic                    write_tag,    // tag array write strobe
	output logic [`ADDR_W-1:0]      cache_addr,   // address seen by both arrays
	output mem_types_pkg::mem_cmd_e mem_cmd,
	output logic [`ADDR_W-1:0]      mem_addr
);

	cache_types_pkg::fill_state_e state, state_nxt;

	logic [`OFFSET_W-1:0]        issue_cnt;  // offset of the next read to send
	logic [`OFFSET_W-1:0]        ret_cnt;    // offset of the next word to come back
	logic [`ADDR_W-1:`OFFSET_W+1] blk_addr;   // block base bits of the request
	logic                        idle;
	logic                        miss_start;
	logic                        write_hit;
	logic                        last_issue;
	logic                        last_ret;

	assign blk_addr   = addr_in[`ADDR_W-1:`OFFSET_W+1];
	assign idle       = (state == cache_types_pkg::ST_IDLE);
	assign miss_start = idle & req & ~hit & ~pause; // held off during icache fill
	assign write_hit  = idle & req & wrt_en & hit;
	assign last_issue = (issue_cnt == '1);
	assign last_ret   = mem_data_vld & (ret_cnt == '1);

	// both counters wrap back to zero at the end of a block,
	// so they are already cleared for the next miss
	always_ff @(posedge clk) begin
		if (reset) begin
			state     <= cache_types_pkg::ST_IDLE;
			issue_cnt <= '0;
			ret_cnt   <= '0;
		end else begin
			state <= state_nxt;
			if (miss_start || state == cache_types_pkg::ST_FETCH) begin
				issue_cnt <= issue_cnt + 1'b1; // offset 0 goes out in the miss cycle
			end
			if (mem_data_vld) begin
				ret_cnt <= ret_cnt + 1'b1;
			end
		end
	end

	always_comb begin
		state_nxt = state;
		case (state)
			cache_types_pkg::ST_IDLE: begin
				if (miss_start) state_nxt = cache_types_pkg::ST_FETCH;
			end
			cache_types_pkg::ST_FETCH: begin
				if (last_issue) state_nxt = cache_types_pkg::ST_DRAIN; // offset 7 sent
			end
			cache_types_pkg::ST_DRAIN: begin
				if (last_ret) state_nxt = cache_types_pkg::ST_TAG;
			end
			cache_types_pkg::ST_TAG: begin
				state_nxt = cache_types_pkg::ST_IDLE; // tag written this cycle
			end
			default: state_nxt = cache_types_pkg::ST_IDLE;
		endcase
	end

	// memory command, reads overlap up to MEM_LATENCY deep
	always_comb begin
		mem_cmd = mem_types_pkg::MEM_NONE;
		if (miss_start || state == cache_types_pkg::ST_FETCH) begin
			mem_cmd = mem_types_pkg::MEM_READ;
		end else if (write_hit) begin
			mem_cmd = mem_types_pkg::MEM_WRITE; // write-through, same edge as the array
		end
	end

	// a write hit uses the request address as is
	assign mem_addr = (idle && !miss_start) ? addr_in : {blk_addr, issue_cnt, 1'b0};

	// stall from the miss cycle on, also while the fill is held off
	assign fsm_busy = ~idle | (req & ~hit);

	assign fill_write = idle ? write_hit : mem_data_vld; // reg_in on a hit, mem_data on fill
	assign write_tag  = (state == cache_types_pkg::ST_TAG);

	// during a fill the arrays follow the returning word
	assign cache_addr = idle ? addr_in : {blk_addr, ret_cnt, 1'b0};

endmodule

`default_nettype wire

// ==== dcache_tag_array.sv ====
/* dcache tag array, one valid bit and tag per block
   compares the stored tag against the request for hit detection */
`timescale 1ns/1ps
`default_nettype none

`include "cache_settings.svh"

module dcache_tag_array (
	input  logic                clk,
	input  logic                reset,
	input  logic [`INDEX_W-1:0] index,     // block select
	input  logic [`TAG_W-1:0]   tag,       // request tag
	input  logic                write_tag, // end of fill, store tag as valid
	output logic                hit
);

	logic [`NUM_BLOCKS-1:0] valid;          // cleared on reset
	logic [`TAG_W-1:0]      tags [`NUM_BLOCKS];
	logic                   tag_match;

	// valid bits are the only control state here
	always_ff @(posedge clk) begin
		if (reset) begin
			valid <= '0;
		end else if (write_tag) begin
			valid[index] <= 1'b1; // a tag is only ever written as valid
		end
	end

	// tag storage, no reset needed behind the valid bits
	always_ff @(posedge clk) begin
		if (write_tag) begin
			tags[index] <= tag;
		end
	end

	assign tag_match = (tags[index] == tag);

	// no hit while the tag is being written, the block
	// only becomes usable the cycle after
	assign hit = valid[index] & tag_match & ~write_tag;

endmodule

`default_nettype wire

// ==== dcache_tb.sv ====
/* data cache testbench with directed and seeded random accesses
   checked against a memory model with a valid/tag shadow */
`timescale 1ns/1ps
`default_nettype none

`include "cache_settings.svh"

module dcache_tb;

	localparam int CLK_PERIOD   = 10;
	localparam int N_RANDOM     = 300;
	localparam int N_DIRECTED   = 16;                   // upper bound for the directed part
	localparam int FILL_CYCLES  = 8 + `MEM_LATENCY + 1; // busy window of one miss
	localparam int PAUSE_CYCLES = FILL_CYCLES + 4;      // icache fill outlasts a whole dcache fill
	localparam int TIMEOUT_NS   = (N_RANDOM + N_DIRECTED) * (FILL_CYCLES + 2) * CLK_PERIOD
		+ 200 * CLK_PERIOD;                             // reset, pause and idle cycles

	logic               clk;
	logic               reset;
	logic               mem_en;
	logic               wrt_en;
	logic [`ADDR_W-1:0] addr_in;
	logic [`ADDR_W-1:0] reg_in;
	logic               ifsm_busy;
	logic [`ADDR_W-1:0] data_out;
	logic               fsm_busy;

	// reference model of memory words and of what the cache should hold
	logic [`ADDR_W-1:0] model_mem [`MEM_WORDS];
	logic               model_valid [`NUM_BLOCKS];
	logic [`TAG_W-1:0]  model_tag [`NUM_BLOCKS];
	int                 errors;
	int                 checks;

	mem_subsystem_top i_dut (
		.clk       (clk),
		.reset     (reset),
		.mem_en    (mem_en),
		.wrt_en    (wrt_en),
		.addr_in   (addr_in),
		.reg_in    (reg_in),
		.ifsm_busy (ifsm_busy),
		.data_out  (data_out),
		.fsm_busy  (fsm_busy)
	);

	always #(CLK_PERIOD / 2) clk = ~clk;

	task automatic check_value(input string name, input logic [`ADDR_W-1:0] expected,
		input logic [`ADDR_W-1:0] actual);
		checks++;
		if (expected !== actual) begin
			errors++;
			$display("ERR %0t ns %s expected %h actual %h", $time, name, expected, actual);
		end
	endtask

	function automatic logic [`ADDR_W-1:0] make_addr(input logic [`TAG_W-1:0] tag,
		input logic [`INDEX_W-1:0] idx, input logic [`OFFSET_W-1:0] off);
		return {tag, idx, off, 1'b0}; // bit 0 always zero
	endfunction

	task automatic init_model();
		for (int w = 0; w < `MEM_WORDS; w++) begin
			model_mem[w] = w[`ADDR_W-1:0] ^ `MEM_INIT_XOR;
		end
		for (int b = 0; b < `NUM_BLOCKS; b++) begin
			model_valid[b] = 1'b0; // cold after reset
			model_tag[b]   = '0;
		end
	endtask

	// sample 1 ns after the falling edge when outputs have settled
	task automatic wait_not_busy();
		while (fsm_busy) begin
			@(negedge clk);
			#1;
		end
	endtask

	// one live request held until the stall drops
	task automatic access(input logic wr, input logic [`ADDR_W-1:0] addr,
		input logic [`ADDR_W-1:0] data);
		logic [`INDEX_W-1:0] idx;
		logic [`TAG_W-1:0]   tag;
		logic [`ADDR_W-2:0]  word;
		logic                exp_miss;
		idx      = addr[`OFFSET_W+1 +: `INDEX_W];
		tag      = addr[`ADDR_W-1 -: `TAG_W];
		word     = addr[`ADDR_W-1:1];
		exp_miss = !model_valid[idx] || (model_tag[idx] != tag);
		@(negedge clk);
		mem_en  = 1'b1;
		wrt_en  = wr;
		addr_in = addr;
		reg_in  = data;
		#1;
		check_value("fsm_busy", {15'd0, exp_miss}, {15'd0, fsm_busy}); // stall only on a miss
		wait_not_busy();
		model_valid[idx] = 1'b1; // allocated on reads and writes alike
		model_tag[idx]   = tag;
		if (wr) begin
			model_mem[word] = data; // write-through commits at the next edge
		end else begin
			check_value("data_out", model_mem[word], data_out);
		end
	endtask

	// cold read with the icache fill holding off the start
	task automatic read_paused(input logic [`ADDR_W-1:0] addr);
		logic [`ADDR_W-2:0] word;
		word = addr[`ADDR_W-1:1];
		@(negedge clk);
		ifsm_busy = 1'b1;
		mem_en    = 1'b1;
		wrt_en    = 1'b0;
		addr_in   = addr;
		reg_in    = '0;
		repeat (PAUSE_CYCLES) begin
			#1;
			check_value("fsm_busy", 16'd1, {15'd0, fsm_busy}); // stalled while held off
			@(negedge clk);
		end
		ifsm_busy = 1'b0; // fill may start now
		#1;
		wait_not_busy();
		check_value("data_out", model_mem[word], data_out);
		model_valid[addr[`OFFSET_W+1 +: `INDEX_W]] = 1'b1;
		model_tag[addr[`OFFSET_W+1 +: `INDEX_W]]   = addr[`ADDR_W-1 -: `TAG_W];
	endtask

	// with mem_en low nothing may stall and nothing may be written
	task automatic disabled_access(input logic wr, input logic [`ADDR_W-1:0] addr,
		input logic [`ADDR_W-1:0] data);
		@(negedge clk);
		mem_en  = 1'b0;
		wrt_en  = wr;
		addr_in = addr;
		reg_in  = data;
		#1;
		check_value("fsm_busy", 16'd0, {15'd0, fsm_busy});
		@(negedge clk);
		#1;
		check_value("fsm_busy", 16'd0, {15'd0, fsm_busy}); // still low across an edge
	endtask

	task automatic run_directed();
		logic [`ADDR_W-1:0] a_addr;
		logic [`ADDR_W-1:0] b_addr;
		logic [`ADDR_W-1:0] c_addr;
		a_addr = make_addr(5'd1, 7'd5, 3'd2);
		b_addr = make_addr(5'd2, 7'd9, 3'd3);
		c_addr = make_addr(5'd3, 7'd5, 3'd2);       // same index as a, other tag
		access(1'b0, a_addr, '0);                   // cold miss
		access(1'b0, make_addr(5'd1, 7'd5, 3'd6), '0); // hit in the same block
		access(1'b1, a_addr, 16'h1234);             // write hit
		access(1'b0, a_addr, '0);
		access(1'b1, b_addr, 16'hbeef);             // write miss, fill then write
		access(1'b0, b_addr, '0);
		access(1'b0, c_addr, '0);                   // evicts a
		access(1'b0, a_addr, '0);                   // 1234 must come back from memory
		access(1'b0, c_addr, '0);
		access(1'b0, a_addr, '0);
		read_paused(make_addr(5'd4, 7'd20, 3'd0));
		disabled_access(1'b1, a_addr, 16'hdead);    // must not land anywhere
		access(1'b0, a_addr, '0);
	endtask

	// small tag and index range so conflicts are frequent
	task automatic run_random();
		logic [31:0]        r;
		logic [`ADDR_W-1:0] addr;
		for (int i = 0; i < N_RANDOM; i++) begin
			r    = $urandom;
			addr = make_addr({3'd0, r[1:0]}, {4'd0, r[4:2]}, r[7:5]);
			if (r[12:9] == 4'd0) begin
				disabled_access(r[8], addr, r[31:16]);
			end else begin
				access(r[8], addr, r[31:16]);
			end
		end
	endtask

	initial begin
		#(TIMEOUT_NS);
		$display("timeout, run did not finish within %0d ns", TIMEOUT_NS);
		$display("Simulation failed");
		$finish;
	end

	initial begin
		clk       = 1'b0;
		reset     = 1'b1;
		mem_en    = 1'b0;
		wrt_en    = 1'b0;
		addr_in   = '0;
		reg_in    = '0;
		ifsm_busy = 1'b0;
		errors    = 0;
		checks    = 0;
		void'($urandom(4));
		init_model();
		repeat (3) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;
		#1;
		check_value("fsm_busy", 16'd0, {15'd0, fsm_busy}); // idle out of reset
		run_directed();
		run_random();
		@(negedge clk); // let the last write commit
		$display("checks %0d, errors %0d", checks, errors);
		if (errors == 0) begin
			$display("Simulation passed");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== main_memory.sv ====
/* main memory model, fixed latency pipelined reads
   and single cycle writes, never stalls */
`timescale 1ns/1ps
`default_nettype none

`include "cache_settings.svh"

module main_memory (
	input  logic                    clk,
	input  logic                    reset,
	input  mem_types_pkg::mem_cmd_e mem_cmd,
	input  logic [`ADDR_W-1:0]      mem_addr,     // byte address, bit 0 ignored
	input  logic [`ADDR_W-1:0]      mem_wdata,
	output logic [`ADDR_W-1:0]      mem_data,
	output logic                    mem_data_vld  // one cycle per read
);

	logic [`ADDR_W-1:0]     mem [`MEM_WORDS];           // word store
	logic [`ADDR_W-2:0]     pipe_addr [`MEM_LATENCY];   // word index per stage
	logic [`MEM_LATENCY-1:0] pipe_vld;                  // read in flight per stage
	logic [`ADDR_W-2:0]     word_idx;
	logic                   rd_cmd;

	assign word_idx = mem_addr[`ADDR_W-1:1];
	assign rd_cmd   = (mem_cmd == mem_types_pkg::MEM_READ);

	// known starting contents, word w holds w ^ MEM_INIT_XOR
	initial begin
		for (int w = 0; w < `MEM_WORDS; w++) begin
			mem[w] = w[`ADDR_W-1:0] ^ `MEM_INIT_XOR;
		end
	end

	// writes land at the edge
	always @(posedge clk) begin
		if (mem_cmd == mem_types_pkg::MEM_WRITE) begin
			mem[word_idx] <= mem_wdata;
		end
	end

	// valid flags, one new read may enter every cycle
	always_ff @(posedge clk) begin
		if (reset) begin
			pipe_vld <= '0;
		end else begin
			pipe_vld <= {pipe_vld[`MEM_LATENCY-2:0], rd_cmd};
		end
	end

	// read addresses travel alongside
	always_ff @(posedge clk) begin
		pipe_addr[0] <= word_idx;
		for (int s = 1; s < `MEM_LATENCY; s++) begin
			pipe_addr[s] <= pipe_addr[s-1];
		end
	end

	// array read at the last stage, MEM_LATENCY cycles after the command
	assign mem_data     = mem[pipe_addr[`MEM_LATENCY-1]];
	assign mem_data_vld = pipe_vld[`MEM_LATENCY-1];

endmodule

`default_nettype wire

// ==== mem_subsystem_top.sv ====
/* memory subsystem top, data cache in front of main memory */
`timescale 1ns/1ps
`default_nettype none

`include "cache_settings.svh"

module mem_subsystem_top (
	input  logic               clk,
	input  logic               reset,
	input  logic               mem_en,
	input  logic               wrt_en,
	input  logic [`ADDR_W-1:0] addr_in,
	input  logic [`ADDR_W-1:0] reg_in,
	input  logic               ifsm_busy, // icache fill in progress
	output logic [`ADDR_W-1:0] data_out,
	output logic               fsm_busy
);

	mem_types_pkg::mem_cmd_e mem_cmd;
	logic [`ADDR_W-1:0]      mem_addr;
	logic [`ADDR_W-1:0]      mem_wdata;
	logic [`ADDR_W-1:0]      mem_data;
	logic                    mem_data_vld;

	dcache u_dcache (
		.clk (clk), .reset (reset),
		.mem_en (mem_en), .wrt_en (wrt_en), .addr_in (addr_in), .reg_in (reg_in),
		.pause (ifsm_busy),
		.mem_data (mem_data), .mem_data_vld (mem_data_vld),
		.data_out (data_out), .fsm_busy (fsm_busy),
		.mem_cmd (mem_cmd), .mem_addr (mem_addr), .mem_wdata (mem_wdata)
	);

	main_memory u_mem (
		.clk (clk), .reset (reset),
		.mem_cmd (mem_cmd), .mem_addr (mem_addr), .mem_wdata (mem_wdata),
		.mem_data (mem_data), .mem_data_vld (mem_data_vld)
	);

endmodule

`default_nettype wire

// ==== mem_types_pkg.sv ====
/* main memory command encoding */
`default_nettype none

package mem_types_pkg;

	// one command per cycle, memory never stalls
	typedef enum logic [1:0] {
		MEM_NONE  = 2'd0, // bus idle
		MEM_READ  = 2'd1, // word read, data back MEM_LATENCY cycles later
		MEM_WRITE = 2'd2  // word write, commits at the clock edge
	} mem_cmd_e;

endpackage

`default_nettype wire

// ==== run_sim.sh ====
#!/bin/sh
# build the data cache testbench with Verilator, run it, then search the log
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f sim.f --top-module dcache_tb -o dcache_sim > build.log 2>&1 \
	|| { cat build.log; echo "verilator build error, see build.log"; exit 1; }

./obj_dir/dcache_sim > sim.log 2>&1
cat sim.log

grep -q "Simulation failed" sim.log && { echo "run reported a failure"; exit 1; }
grep -q "Simulation passed" sim.log || { echo "no pass line in sim.log"; exit 1; }
echo "run ok"

// ==== sim.f ====
+incdir+.
cache_types_pkg.sv
mem_types_pkg.sv
dcache_tag_array.sv
dcache_data_array.sv
dcache_fill_fsm.sv
main_memory.sv
dcache.sv
mem_subsystem_top.sv
dcache_tb.sv
